// ==== source/fft_packetize_pkg.sv ====
// shared constants for the FFT packetizer
// sample, length and timestamp widths
// FFT size limits and side queue depth
// state codes of the symbol framer

package fft_packetize_pkg;

  // --------------------------------------------------
  // data and burst field widths
  // --------------------------------------------------

  // one complex sample as it travels to the FFT core
  localparam int ITEM_W = 32;

  // the shell gives packet lengths in bytes, so this turns bytes into items
  localparam int ITEM_BYTES = ITEM_W / 8;

  localparam int LENGTH_W    = 16;
  localparam int TIMESTAMP_W = 64;
  localparam int PKT_SIZE_W  = 12;

  // --------------------------------------------------
  // FFT and cyclic prefix sizes
  // --------------------------------------------------

  // largest FFT is 2**10 = 1024 items
  localparam int MAX_FFT_SIZE_LOG2 = 10;
  localparam int FFT_SIZE_LOG2_W   = $clog2(MAX_FFT_SIZE_LOG2 + 1);

  // one spare bit so FFT size plus the longest prefix still fits
  localparam int FFT_SIZE_W = MAX_FFT_SIZE_LOG2 + 1;
  localparam int CP_LEN_W   = MAX_FFT_SIZE_LOG2;

  // each side queue holds 32 entries
  localparam int INFO_FIFO_DEPTH_LOG2 = 5;

  // --------------------------------------------------
  // framer state codes
  // --------------------------------------------------

  localparam logic [1:0] ST_WAIT_BURST    = 2'd0;
  localparam logic [1:0] ST_GET_PREFIX    = 2'd1;
  localparam logic [1:0] ST_PASS_SYMBOL   = 2'd2;
  localparam logic [1:0] ST_FINISH_SYMBOL = 2'd3;

endpackage

// ==== source/info_fifo.sv ====
// small synchronous FIFO with valid/ready on both sides
// circular buffer addressed by read and write pointers
// an occupancy count gives the full and empty flags

`timescale 1ns/1ps

module info_fifo #(
  parameter int WIDTH      = 8,
  parameter int DEPTH_LOG2 = 5
) (
  input  logic             clk,
  input  logic             rst,

  // write side
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_valid,
  output logic             o_ready,

  // read side
  output logic [WIDTH-1:0] o_data,
  output logic             o_valid,
  input  logic             i_ready
);

  localparam int DEPTH = 2 ** DEPTH_LOG2;

  // storage has no reset, only the pointers and count are cleared
  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  // one bit wider than the pointers so that a full queue can be told apart
  logic [DEPTH_LOG2:0]   count;

  logic do_write;
  logic do_read;

  assign o_ready = (count != (DEPTH_LOG2 + 1)'(DEPTH));
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];

  assign do_write = i_valid && o_ready;
  assign do_read  = o_valid && i_ready;

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // the pointers wrap on their own since the depth is a power of two
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // a write and a read together leave the count unchanged
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== source/symbol_framer.sv ====
// symbol framer FSM for the FFT packetizer
// accepts bursts, cuts them into FFT size plus prefix symbols
// pads a short final symbol with held data
// writes the prefix, burst and symbol side queues

`timescale 1ns/1ps

module symbol_framer (
  input  logic                                      clk,
  input  logic                                      rst,

  input  logic [fft_packetize_pkg::FFT_SIZE_LOG2_W-1:0] i_fft_size_log2,

  // cyclic prefix length, sampled as a level
  input  logic [fft_packetize_pkg::CP_LEN_W-1:0]    i_cp_len,
  output logic                                      o_cp_wr,

  // input stream from the network shell
  input  logic [fft_packetize_pkg::ITEM_W-1:0]      i_noc_tdata,
  input  logic                                      i_noc_tlast,
  input  logic                                      i_noc_teob,
  input  logic [fft_packetize_pkg::LENGTH_W-1:0]    i_noc_tlength,
  input  logic [fft_packetize_pkg::TIMESTAMP_W-1:0] i_noc_ttimestamp,
  input  logic                                      i_noc_thas_time,
  input  logic                                      i_noc_tvalid,
  output logic                                      o_noc_tready,

  // output stream to the FFT core
  output logic [fft_packetize_pkg::ITEM_W-1:0]      o_fft_tdata,
  output logic                                      o_fft_tlast,
  output logic                                      o_fft_tvalid,
  input  logic                                      i_fft_tready,

  // room in the side queues
  input  logic                                      i_cp_fifo_ready,
  input  logic                                      i_burst_fifo_ready,
  input  logic                                      i_symb_fifo_ready,

  // burst info write
  output logic                                      o_burst_wr,
  output logic [fft_packetize_pkg::PKT_SIZE_W-1:0]  o_pkt_size,
  output logic [fft_packetize_pkg::TIMESTAMP_W-1:0] o_timestamp,
  output logic                                      o_has_time,

  // symbol info write
  output logic                                      o_symb_wr,
  output logic                                      o_last_symbol
);

  import fft_packetize_pkg::*;

  // --------------------------------------------------
  // FFT size register
  // --------------------------------------------------

  // the size input is expected to be stable well before a burst arrives,
  // so one cycle of delay here costs nothing
  logic [FFT_SIZE_W-1:0] fft_size;

  always_ff @(posedge clk) begin
    fft_size <= FFT_SIZE_W'(1) << i_fft_size_log2;
  end

  // --------------------------------------------------
  // state and symbol tracking
  // --------------------------------------------------

  logic [1:0]            state;
  // FFT size plus the prefix of the symbol in progress
  logic [FFT_SIZE_W-1:0] symbol_size;
  // items already sent in the current symbol
  logic [FFT_SIZE_W-1:0] item_count;
  // last input item, repeated while padding a short symbol
  logic [ITEM_W-1:0]     data_hold;

  logic symbol_end;
  logic burst_end;
  logic noc_xfer;
  logic burst_accept;
  logic prefix_take;

  // one item per cycle, so the final item is known straight from the counter
  assign symbol_end = (item_count == symbol_size - FFT_SIZE_W'(1));
  assign burst_end  = i_noc_tlast && i_noc_teob;
  assign noc_xfer   = i_noc_tvalid && i_fft_tready;

  // a new burst needs room for its burst entry and its first symbol
  assign burst_accept = i_noc_tvalid && i_cp_fifo_ready && i_burst_fifo_ready &&
                        i_symb_fifo_ready;
  assign prefix_take  = i_symb_fifo_ready && i_cp_fifo_ready;

  // the prefix length goes into its queue on the same cycle it sizes the symbol
  assign o_cp_wr = (state == ST_GET_PREFIX) && prefix_take;

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= ST_WAIT_BURST;
      item_count    <= '0;
      o_burst_wr    <= 1'b0;
      o_symb_wr     <= 1'b0;
      o_last_symbol <= 1'b0;
    end else begin
      // write strobes last a single cycle
      o_burst_wr <= 1'b0;
      o_symb_wr  <= 1'b0;

      case (state)
        ST_WAIT_BURST: begin
          item_count <= '0;
          if (burst_accept) begin
            o_burst_wr <= 1'b1;
            state      <= ST_GET_PREFIX;
          end
        end

        ST_GET_PREFIX: begin
          item_count <= '0;
          // wait here while the symbol or prefix queue is full
          if (prefix_take) begin
            state <= ST_PASS_SYMBOL;
          end
        end

        ST_PASS_SYMBOL: begin
          if (noc_xfer) begin
            if (symbol_end) begin
              o_symb_wr <= 1'b1;
              if (burst_end) begin
                // burst and symbol finish together
                o_last_symbol <= 1'b1;
                state         <= ST_WAIT_BURST;
              end else begin
                o_last_symbol <= 1'b0;
                state         <= ST_GET_PREFIX;
              end
            end else begin
              item_count <= item_count + 1'b1;
              // burst ran out mid-symbol, so the rest is filler
              if (burst_end) begin
                state <= ST_FINISH_SYMBOL;
              end
            end
          end
        end

        ST_FINISH_SYMBOL: begin
          if (i_fft_tready) begin
            if (symbol_end) begin
              o_symb_wr     <= 1'b1;
              o_last_symbol <= 1'b1;
              state         <= ST_WAIT_BURST;
            end else begin
              item_count <= item_count + 1'b1;
            end
          end
        end

        default: begin
          state <= ST_WAIT_BURST;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // burst fields and symbol size
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    // the shell fields are sampled every waiting cycle, the accepting one sticks
    if (state == ST_WAIT_BURST) begin
      o_timestamp <= i_noc_ttimestamp;
      o_has_time  <= i_noc_thas_time;
      o_pkt_size  <= PKT_SIZE_W'(i_noc_tlength / ITEM_BYTES);
    end
    if (o_cp_wr) begin
      symbol_size <= fft_size + FFT_SIZE_W'(i_cp_len);
    end
    if ((state == ST_PASS_SYMBOL) && noc_xfer) begin
      data_hold <= i_noc_tdata;
    end
  end

  // --------------------------------------------------
  // data path
  // --------------------------------------------------

  always_comb begin
    o_fft_tdata  = i_noc_tdata;
    o_fft_tlast  = 1'b0;
    o_fft_tvalid = 1'b0;
    o_noc_tready = 1'b0;

    case (state)
      ST_PASS_SYMBOL: begin
        // straight through with no latency
        o_fft_tlast  = symbol_end;
        o_fft_tvalid = i_noc_tvalid;
        o_noc_tready = i_fft_tready;
      end
      ST_FINISH_SYMBOL: begin
        // input stays stalled while the filler goes out
        o_fft_tdata  = data_hold;
        o_fft_tlast  = symbol_end;
        o_fft_tvalid = 1'b1;
      end
      default: begin
        o_fft_tvalid = 1'b0;
      end
    endcase
  end

endmodule

// ==== source/fft_packetize.sv ====
// FFT packetizer top level
// symbol framer plus three side queues for prefix lengths,
// burst info and per-symbol info

`timescale 1ns/1ps

module fft_packetize (
  input  logic                                          clk,
  input  logic                                          rst,

  input  logic [fft_packetize_pkg::FFT_SIZE_LOG2_W-1:0] i_fft_size_log2,

  // cyclic prefix length in, read as a level on each new symbol
  input  logic [fft_packetize_pkg::CP_LEN_W-1:0]        i_cp_rem_tdata,
  output logic                                          o_cp_rem_ready,

  // input stream from the network shell
  input  logic [fft_packetize_pkg::ITEM_W-1:0]          i_noc_tdata,
  input  logic                                          i_noc_tlast,
  input  logic                                          i_noc_teob,
  input  logic [fft_packetize_pkg::LENGTH_W-1:0]        i_noc_tlength,
  input  logic [fft_packetize_pkg::TIMESTAMP_W-1:0]     i_noc_ttimestamp,
  input  logic                                          i_noc_thas_time,
  input  logic                                          i_noc_tvalid,
  output logic                                          o_noc_tready,

  // output stream to the FFT core
  output logic [fft_packetize_pkg::ITEM_W-1:0]          o_fft_tdata,
  output logic                                          o_fft_tlast,
  output logic                                          o_fft_tvalid,
  input  logic                                          i_fft_tready,

  // prefix lengths for the removal logic
  output logic [fft_packetize_pkg::CP_LEN_W-1:0]        o_cp_rem_tdata,
  output logic                                          o_cp_rem_tvalid,
  input  logic                                          i_cp_rem_tready,

  // one entry per burst
  output logic [fft_packetize_pkg::PKT_SIZE_W-1:0]      o_burst_pkt_size,
  output logic [fft_packetize_pkg::TIMESTAMP_W-1:0]     o_burst_timestamp,
  output logic                                          o_burst_has_time,
  output logic                                          o_burst_tvalid,
  input  logic                                          i_burst_tready,

  // one entry per symbol, set on the final symbol of a burst
  output logic                                          o_symbol_last,
  output logic                                          o_symbol_tvalid,
  input  logic                                          i_symbol_tready
);

  import fft_packetize_pkg::*;

  // --------------------------------------------------
  // framer to queue wiring
  // --------------------------------------------------

  logic                   cp_fifo_ready;
  logic                   burst_fifo_ready;
  logic                   symb_fifo_ready;

  logic                   burst_wr;
  logic [PKT_SIZE_W-1:0]  pkt_size;
  logic [TIMESTAMP_W-1:0] timestamp;
  logic                   has_time;

  logic                   symb_wr;
  logic                   last_symbol;

  symbol_framer u_framer (
    .clk               (clk),
    .rst               (rst),
    .i_fft_size_log2   (i_fft_size_log2),
    .i_cp_len          (i_cp_rem_tdata),
    .o_cp_wr           (o_cp_rem_ready),
    .i_noc_tdata       (i_noc_tdata),
    .i_noc_tlast       (i_noc_tlast),
    .i_noc_teob        (i_noc_teob),
    .i_noc_tlength     (i_noc_tlength),
    .i_noc_ttimestamp  (i_noc_ttimestamp),
    .i_noc_thas_time   (i_noc_thas_time),
    .i_noc_tvalid      (i_noc_tvalid),
    .o_noc_tready      (o_noc_tready),
    .o_fft_tdata       (o_fft_tdata),
    .o_fft_tlast       (o_fft_tlast),
    .o_fft_tvalid      (o_fft_tvalid),
    .i_fft_tready      (i_fft_tready),
    .i_cp_fifo_ready   (cp_fifo_ready),
    .i_burst_fifo_ready(burst_fifo_ready),
    .i_symb_fifo_ready (symb_fifo_ready),
    .o_burst_wr        (burst_wr),
    .o_pkt_size        (pkt_size),
    .o_timestamp       (timestamp),
    .o_has_time        (has_time),
    .o_symb_wr         (symb_wr),
    .o_last_symbol     (last_symbol)
  );

  // --------------------------------------------------
  // side queues
  // --------------------------------------------------

  // the prefix strobe from the framer is also the ready pulse back to the source
  info_fifo #(
    .WIDTH     (CP_LEN_W),
    .DEPTH_LOG2(INFO_FIFO_DEPTH_LOG2)
  ) u_cp_fifo (
    .clk    (clk),
    .rst    (rst),
    .i_data (i_cp_rem_tdata),
    .i_valid(o_cp_rem_ready),
    .o_ready(cp_fifo_ready),
    .o_data (o_cp_rem_tdata),
    .o_valid(o_cp_rem_tvalid),
    .i_ready(i_cp_rem_tready)
  );

  // burst word is timestamp, has-time flag and packet size, top bits first
  logic [TIMESTAMP_W+PKT_SIZE_W:0] burst_wr_word;
  logic [TIMESTAMP_W+PKT_SIZE_W:0] burst_rd_word;

  assign burst_wr_word = {timestamp, has_time, pkt_size};
  assign {o_burst_timestamp, o_burst_has_time, o_burst_pkt_size} = burst_rd_word;

  info_fifo #(
    .WIDTH     (TIMESTAMP_W + 1 + PKT_SIZE_W),
    .DEPTH_LOG2(INFO_FIFO_DEPTH_LOG2)
  ) u_burst_fifo (
    .clk    (clk),
    .rst    (rst),
    .i_data (burst_wr_word),
    .i_valid(burst_wr),
    .o_ready(burst_fifo_ready),
    .o_data (burst_rd_word),
    .o_valid(o_burst_tvalid),
    .i_ready(i_burst_tready)
  );

  info_fifo #(
    .WIDTH     (1),
    .DEPTH_LOG2(INFO_FIFO_DEPTH_LOG2)
  ) u_symbol_fifo (
    .clk    (clk),
    .rst    (rst),
    .i_data (last_symbol),
    .i_valid(symb_wr),
    .o_ready(symb_fifo_ready),
    .o_data (o_symbol_last),
    .o_valid(o_symbol_tvalid),
    .i_ready(i_symbol_tready)
  );

endmodule

// ==== testbench/tb_model.svh ====
// testbench model for the FFT packetizer
// Galois LFSR for random stimulus
// reference framing of a burst into symbols
// compare tasks, one for each kind of result

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0] lfsr_state = 32'h0a77dcd6;

// one step of the Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] cur);
  if (cur[0]) begin
    return (cur >> 1) ^ 32'h8020_0003;
  end
  return cur >> 1;
endfunction

// n random bits, the LFSR moves once for every bit taken
function automatic logic [63:0] take_bits(input int n);
  logic [63:0] val;
  val = '0;
  for (int i = 0; i < n; i++) begin
    val = {val[62:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
  return val;
endfunction

// prefix of symbol k in the current test, zero once the list runs out
function automatic logic [CP_LEN_W-1:0] cp_at(input int k);
  if (k < cp_list.size()) begin
    return cp_list[k];
  end
  return '0;
endfunction

// --------------------------------------------------
// reference framing
// --------------------------------------------------

// cuts a burst of n items into symbols of fft plus prefix items each
// appends every symbol length and its last-of-burst flag, returns the filler count
function automatic int frame_burst(input int n, input int fft, input int first_sym);
  int left;
  int sym;
  int k;
  int pad;
  left = n;
  k = first_sym;
  pad = 0;
  while (left > 0) begin
    sym = fft + int'(cp_at(k));
    exp_len.push_back(sym);
    exp_last.push_back(left <= sym);
    // a burst that stops inside a symbol is topped up to the full length
    if (left < sym) begin
      pad = sym - left;
    end
    left = left - sym;
    k++;
  end
  return pad;
endfunction

// --------------------------------------------------
// compare tasks
// --------------------------------------------------

task automatic check_item(input string name, input logic [ITEM_W-1:0] got,
                          input logic [ITEM_W-1:0] exp);
  if (got !== exp) begin
    $display("Fail %s: got %h, expected %h", name, got, exp);
    err_count++;
  end
endtask

task automatic check_len(input string name, input logic [FFT_SIZE_W-1:0] got,
                         input logic [FFT_SIZE_W-1:0] exp);
  if (got !== exp) begin
    $display("Fail %s: got %h, expected %h", name, got, exp);
    err_count++;
  end
endtask

task automatic check_cp(input string name, input logic [CP_LEN_W-1:0] got,
                        input logic [CP_LEN_W-1:0] exp);
  if (got !== exp) begin
    $display("Fail %s: got %h, expected %h", name, got, exp);
    err_count++;
  end
endtask

task automatic check_pkt(input string name, input logic [PKT_SIZE_W-1:0] got,
                         input logic [PKT_SIZE_W-1:0] exp);
  if (got !== exp) begin
    $display("Fail %s: got %h, expected %h", name, got, exp);
    err_count++;
  end
endtask

task automatic check_time(input string name, input logic [TIMESTAMP_W-1:0] got,
                          input logic [TIMESTAMP_W-1:0] exp);
  if (got !== exp) begin
    $display("Fail %s: got %h, expected %h", name, got, exp);
    err_count++;
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("Fail %s: got %h, expected %h", name, got, exp);
    err_count++;
  end
endtask

`endif

// ==== testbench/tb_fft_packetize.sv ====
// testbench for the FFT packetizer
// clock, reset, burst driver, prefix source and ready patterns
// monitors on every output stream and a checker process
// five directed tests with random prefixes and back-pressure

`timescale 1ns/1ps

module tb_fft_packetize;

  import fft_packetize_pkg::*;

  localparam int ITEM_TIMEOUT  = 2000;
  localparam int DRAIN_TIMEOUT = 4000;
  localparam int CHECK_TIMEOUT = 20;

  logic                   clk;
  logic                   rst;
  logic [FFT_SIZE_LOG2_W-1:0] i_fft_size_log2;
  logic [CP_LEN_W-1:0]    i_cp_rem_tdata;
  logic                   o_cp_rem_ready;
  logic [ITEM_W-1:0]      i_noc_tdata;
  logic                   i_noc_tlast;
  logic                   i_noc_teob;
  logic [LENGTH_W-1:0]    i_noc_tlength;
  logic [TIMESTAMP_W-1:0] i_noc_ttimestamp;
  logic                   i_noc_thas_time;
  logic                   i_noc_tvalid;
  logic                   o_noc_tready;
  logic [ITEM_W-1:0]      o_fft_tdata;
  logic                   o_fft_tlast;
  logic                   o_fft_tvalid;
  logic                   i_fft_tready;
  logic [CP_LEN_W-1:0]    o_cp_rem_tdata;
  logic                   o_cp_rem_tvalid;
  logic                   i_cp_rem_tready;
  logic [PKT_SIZE_W-1:0]  o_burst_pkt_size;
  logic [TIMESTAMP_W-1:0] o_burst_timestamp;
  logic                   o_burst_has_time;
  logic                   o_burst_tvalid;
  logic                   i_burst_tready;
  logic                   o_symbol_last;
  logic                   o_symbol_tvalid;
  logic                   i_symbol_tready;

  // prefixes handed to the DUT, expected streams and collected streams
  logic [CP_LEN_W-1:0]    cp_list[$];
  int                     exp_len[$];
  bit                     exp_last[$];
  logic [ITEM_W-1:0]      exp_data[$];
  bit                     exp_care[$];
  logic [PKT_SIZE_W-1:0]  exp_pkt[$];
  logic [TIMESTAMP_W-1:0] exp_ts[$];
  bit                     exp_ht[$];
  logic [ITEM_W-1:0]      got_data[$];
  bit                     got_last[$];
  logic [CP_LEN_W-1:0]    got_cp[$];
  logic [PKT_SIZE_W-1:0]  got_pkt[$];
  logic [TIMESTAMP_W-1:0] got_ts[$];
  bit                     got_ht[$];
  bit                     got_sym[$];

  int    err_count = 0;
  int    errs_at_start = 0;
  int    test_fail = 0;
  int    test_num = 0;
  int    cp_idx = 0;
  int    cur_fft = 16;
  string test_name;
  bit    bp_en = 1'b0;
  bit    hold_side = 1'b0;
  bit    check_req = 1'b0;
  bit    run_done = 1'b0;
  bit    timed_out = 1'b0;
  bit    sent_done = 1'b0;

  `include "tb_model.svh"

  fft_packetize u_dut (
    .clk(clk), .rst(rst), .i_fft_size_log2(i_fft_size_log2),
    .i_cp_rem_tdata(i_cp_rem_tdata), .o_cp_rem_ready(o_cp_rem_ready),
    .i_noc_tdata(i_noc_tdata), .i_noc_tlast(i_noc_tlast), .i_noc_teob(i_noc_teob),
    .i_noc_tlength(i_noc_tlength), .i_noc_ttimestamp(i_noc_ttimestamp),
    .i_noc_thas_time(i_noc_thas_time), .i_noc_tvalid(i_noc_tvalid),
    .o_noc_tready(o_noc_tready),
    .o_fft_tdata(o_fft_tdata), .o_fft_tlast(o_fft_tlast), .o_fft_tvalid(o_fft_tvalid),
    .i_fft_tready(i_fft_tready),
    .o_cp_rem_tdata(o_cp_rem_tdata), .o_cp_rem_tvalid(o_cp_rem_tvalid),
    .i_cp_rem_tready(i_cp_rem_tready),
    .o_burst_pkt_size(o_burst_pkt_size), .o_burst_timestamp(o_burst_timestamp),
    .o_burst_has_time(o_burst_has_time), .o_burst_tvalid(o_burst_tvalid),
    .i_burst_tready(i_burst_tready),
    .o_symbol_last(o_symbol_last), .o_symbol_tvalid(o_symbol_tvalid),
    .i_symbol_tready(i_symbol_tready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    timed_out = 1'b1;
  endtask

  // holds the current item until the edge that takes it
  // ready is read at the falling edge, where every input has settled
  task automatic push_item();
    int  cyc;
    logic took;
    cyc = 0;
    took = 1'b0;
    while (!took && cyc < ITEM_TIMEOUT) begin
      @(negedge clk);
      took = o_noc_tready;
      @(posedge clk);
      #2;
      cyc++;
    end
    if (!took) begin
      report_timeout("an input item was never accepted");
    end
  endtask

  // computes the expected streams for one burst, then sends it
  task automatic burst(input int n, input int base, input logic [63:0] ts, input bit ht);
    int pad;
    if (timed_out) begin
      return;
    end
    pad = frame_burst(n, cur_fft, exp_len.size());
    for (int i = 0; i < n + pad; i++) begin
      exp_data.push_back(ITEM_W'(base + i));
      exp_care.push_back(i < n);
    end
    exp_pkt.push_back(PKT_SIZE_W'((n * ITEM_BYTES) / ITEM_BYTES));
    exp_ts.push_back(ts);
    exp_ht.push_back(ht);
    i_noc_tlength    = LENGTH_W'(n * ITEM_BYTES);
    i_noc_ttimestamp = ts;
    i_noc_thas_time  = ht;
    for (int i = 0; i < n && !timed_out; i++) begin
      i_noc_tdata  = ITEM_W'(base + i);
      i_noc_tlast  = (i == n - 1);
      i_noc_teob   = (i == n - 1);
      i_noc_tvalid = 1'b1;
      push_item();
    end
    i_noc_tvalid = 1'b0;
    i_noc_tlast  = 1'b0;
    i_noc_teob   = 1'b0;
  endtask

  task automatic start_test(input int num, input string name, input int size_log2);
    test_num  = num;
    test_name = name;
    errs_at_start = err_count;
    i_fft_size_log2 = FFT_SIZE_LOG2_W'(size_log2);
    cur_fft = 1 << size_log2;
    cp_list.delete();
    cp_idx = 0;
  endtask

  function automatic bit outputs_pending();
    return got_data.size() < exp_data.size() || got_cp.size() < exp_len.size() ||
           got_pkt.size() < exp_pkt.size() || got_sym.size() < exp_last.size();
  endfunction

  // waits for every stream to drain, then hands over to the checker
  task automatic finish_test();
    int cyc;
    if (timed_out) begin
      return;
    end
    cyc = 0;
    while (outputs_pending() && cyc < DRAIN_TIMEOUT) begin
      idle(1);
      cyc++;
    end
    if (outputs_pending()) begin
      report_timeout("output streams stopped before all expected items came out");
      return;
    end
    // a few more cycles so that surplus items would be caught too
    idle(10);
    check_req = 1'b1;
    cyc = 0;
    while (check_req && cyc < CHECK_TIMEOUT) begin
      idle(1);
      cyc++;
    end
    if (check_req) begin
      report_timeout("the checker did not finish");
    end
  endtask

  // --------------------------------------------------
  // background processes
  // --------------------------------------------------

  // prefix level moves on to the next list entry after each sampling pulse
  initial begin : prefix_source
    logic took;
    while (!run_done) begin
      @(negedge clk);
      took = o_cp_rem_ready;
      @(posedge clk);
      #2;
      if (took) begin
        cp_idx++;
      end
      i_cp_rem_tdata = cp_at(cp_idx);
    end
  end

  // readies are high unless back-pressure or a held side queue says otherwise
  initial begin : ready_pattern
    while (!run_done) begin
      @(posedge clk);
      #2;
      i_fft_tready    = bp_en ? (take_bits(2) != 0) : 1'b1;
      i_cp_rem_tready = !hold_side && (!bp_en || take_bits(2) != 0);
      i_burst_tready  = !hold_side && (!bp_en || take_bits(2) != 0);
      i_symbol_tready = !hold_side && (!bp_en || take_bits(2) != 0);
    end
  end

  // every output stream is recorded at the falling edge, when a transfer is certain
  initial begin : monitors
    while (!run_done) begin
      @(negedge clk);
      if (o_fft_tvalid && i_fft_tready) begin
        got_data.push_back(o_fft_tdata);
        got_last.push_back(o_fft_tlast);
      end
      if (o_cp_rem_tvalid && i_cp_rem_tready) begin
        got_cp.push_back(o_cp_rem_tdata);
      end
      if (o_burst_tvalid && i_burst_tready) begin
        got_pkt.push_back(o_burst_pkt_size);
        got_ts.push_back(o_burst_timestamp);
        got_ht.push_back(o_burst_has_time);
      end
      if (o_symbol_tvalid && i_symbol_tready) begin
        got_sym.push_back(o_symbol_last);
      end
    end
  end

  // --------------------------------------------------
  // checker
  // --------------------------------------------------

  task automatic compare_streams();
    int run;
    int sym;
    if (got_data.size() != exp_data.size()) begin
      $display("FFT stream carried %0d items where %0d were expected",
               got_data.size(), exp_data.size());
      err_count++;
    end
    run = 0;
    sym = 0;
    for (int i = 0; i < got_data.size(); i++) begin
      if (i < exp_data.size() && exp_care[i]) begin
        check_item("o_fft_tdata", got_data[i], exp_data[i]);
      end
      run++;
      // the distance between last flags is the symbol length
      if (got_last[i]) begin
        if (sym < exp_len.size()) begin
          check_len("o_fft_tlast spacing", FFT_SIZE_W'(run), FFT_SIZE_W'(exp_len[sym]));
        end
        sym++;
        run = 0;
      end
    end
    if (sym != exp_len.size() || got_cp.size() != exp_len.size()) begin
      $display("saw %0d symbols and %0d prefixes where %0d were expected",
               sym, got_cp.size(), exp_len.size());
      err_count++;
    end
    for (int i = 0; i < got_cp.size() && i < exp_len.size(); i++) begin
      check_cp("o_cp_rem_tdata", got_cp[i], cp_at(i));
    end
    if (got_pkt.size() != exp_pkt.size() || got_sym.size() != exp_last.size()) begin
      $display("burst or symbol queue gave the wrong number of entries");
      err_count++;
    end
    for (int i = 0; i < got_pkt.size() && i < exp_pkt.size(); i++) begin
      check_pkt("o_burst_pkt_size", got_pkt[i], exp_pkt[i]);
      check_time("o_burst_timestamp", got_ts[i], exp_ts[i]);
      check_flag("o_burst_has_time", got_ht[i], exp_ht[i]);
    end
    for (int i = 0; i < got_sym.size() && i < exp_last.size(); i++) begin
      check_flag("o_symbol_last", got_sym[i], exp_last[i]);
    end
    if (err_count != errs_at_start) begin
      test_fail++;
    end
    $display("test %0d %s: %0d errors", test_num, test_name, err_count - errs_at_start);
    exp_len.delete();
    exp_last.delete();
    exp_data.delete();
    exp_care.delete();
    exp_pkt.delete();
    exp_ts.delete();
    exp_ht.delete();
    got_data.delete();
    got_last.delete();
    got_cp.delete();
    got_pkt.delete();
    got_ts.delete();
    got_ht.delete();
    got_sym.delete();
  endtask

  initial begin : stream_checker
    while (!run_done) begin
      @(posedge clk);
      if (check_req) begin
        compare_streams();
        check_req = 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------

  initial begin : test_flow
    int total;
    logic [TIMESTAMP_W-1:0] bp_ts[4];
    rst              = 1'b1;
    i_fft_size_log2  = FFT_SIZE_LOG2_W'(4);
    i_cp_rem_tdata   = '0;
    i_noc_tdata      = '0;
    i_noc_tlast      = 1'b0;
    i_noc_teob       = 1'b0;
    i_noc_tlength    = '0;
    i_noc_ttimestamp = '0;
    i_noc_thas_time  = 1'b0;
    i_noc_tvalid     = 1'b0;
    i_fft_tready     = 1'b1;
    i_cp_rem_tready  = 1'b1;
    i_burst_tready   = 1'b1;
    i_symbol_tready  = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    idle(2);

    // four whole symbols of 16 with no prefix
    start_test(1, "whole symbols", 4);
    idle(3);
    burst(64, 32'h100, 64'h0, 1'b0);
    finish_test();

    // burst length is the sum of five random symbol lengths
    start_test(2, "cyclic prefix", 4);
    total = 0;
    repeat (5) begin
      cp_list.push_back(CP_LEN_W'(take_bits(4)));
      total = total + 16 + int'(cp_list[cp_list.size() - 1]);
    end
    idle(3);
    burst(total, 32'h2000, 64'h0, 1'b0);
    finish_test();

    // 30 items against symbols of 20 and 18, so 8 filler items follow
    start_test(3, "short final symbol", 4);
    cp_list.push_back(CP_LEN_W'(4));
    cp_list.push_back(CP_LEN_W'(2));
    idle(3);
    burst(30, 32'h3000, 64'h0, 1'b0);
    finish_test();

    start_test(4, "burst info", 3);
    repeat (12) cp_list.push_back(CP_LEN_W'(take_bits(3)));
    idle(3);
    burst(24, 32'h4000, take_bits(64), 1'b1);
    burst(13, 32'h5000, take_bits(64), 1'b0);
    burst(40, 32'h6000, take_bits(64), 1'b1);
    finish_test();

    // about 40 symbols, more than a side queue holds while nothing reads them
    start_test(5, "back-pressure", 2);
    repeat (64) cp_list.push_back(CP_LEN_W'(take_bits(2)));
    // timestamps are drawn before the ready pattern starts taking LFSR bits
    foreach (bp_ts[i]) bp_ts[i] = take_bits(64);
    idle(3);
    bp_en = 1'b1;
    hold_side = 1'b1;
    sent_done = 1'b0;
    fork
      begin
        burst(58, 32'h7000, bp_ts[0], 1'b1);
        burst(61, 32'h8000, bp_ts[1], 1'b0);
        burst(47, 32'h9000, bp_ts[2], 1'b1);
        burst(66, 32'ha000, bp_ts[3], 1'b0);
        sent_done = 1'b1;
      end
      begin
        idle(600);
        if (sent_done) begin
          $display("side queues never filled, so input acceptance was not stalled");
          err_count++;
        end
        hold_side = 1'b0;
      end
    join
    finish_test();
    bp_en = 1'b0;

    run_done = 1'b1;
    $display("%0d tests run, %0d failed, %0d check errors", test_num, test_fail, err_count);
    if (err_count == 0 && test_fail == 0 && !timed_out) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+testbench
source/fft_packetize_pkg.sv
source/info_fifo.sv
source/symbol_framer.sv
source/fft_packetize.sv
testbench/tb_fft_packetize.sv

// ==== Makefile ====
# Verilator build and run for the FFT packetizer testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall
TOP       := tb_fft_packetize
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

# the run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
